// File: alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    input  rv_isa_pkg::inst_t i_inst,
    input  rv_isa_pkg::data_t i_pc,
    input  rv_isa_pkg::data_t i_rs1_data,
    input  rv_isa_pkg::data_t i_rs2_data,
    input  rv_isa_pkg::data_t i_imm,
    output rv_isa_pkg::data_t o_result
);

    rv_isa_pkg::opcode_t op;
    rv_isa_pkg::data_t   op_a;
    rv_isa_pkg::data_t   op_b;
    logic [2:0]          funct3;
    logic                alt;           // funct7 bit 5
    logic [4:0]          shamt;

    assign op     = rv_isa_pkg::opcode_t'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign alt    = i_inst[30];
    assign op_a   = i_rs1_data;
    assign op_b   = (op == rv_isa_pkg::OPCODE_OP) ? i_rs2_data : i_imm;
    assign shamt  = op_b[4:0];

    always_comb
    begin
        if (op == rv_isa_pkg::OPCODE_LUI)
            o_result = i_imm;
        else if (op == rv_isa_pkg::OPCODE_AUIPC)
            o_result = i_pc + i_imm;
        else
        begin
            case (funct3)
                3'b000:  o_result = (op == rv_isa_pkg::OPCODE_OP && alt) ? op_a - op_b
                                                                         : op_a + op_b;
                3'b001:  o_result = op_a << shamt;
                3'b010:  o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                3'b011:  o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, op_a < op_b};
                3'b100:  o_result = op_a ^ op_b;
                3'b101:  o_result = alt ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
                3'b110:  o_result = op_a | op_b;
                default: o_result = op_a & op_b;
            endcase
        end
    end

endmodule

// File: compile.f
+incdir+.
rv_isa_pkg.sv
exec_pkg.sv
regfile_if.sv
stream_fifo.sv
inst_decoder.sv
alu_unit.sv
reg_file.sv
exec_control.sv
rv_exec_unit.sv
tb_rv_exec_unit.sv

// File: exec_control.sv
`timescale 1ns/10ps

module exec_control (
    input  logic                  i_head_valid,
    output logic                  o_head_ready,
    input  exec_pkg::fetch_t      i_head,
    output logic                  o_ret_valid,
    input  logic                  i_ret_ready,
    output exec_pkg::retire_t     o_ret,
    regfile_if.control            rf,
    input  rv_isa_pkg::opcode_t   i_inst_op,
    input  rv_isa_pkg::gpr_addr_t i_inst_rs1,
    input  rv_isa_pkg::gpr_addr_t i_inst_rs2,
    input  rv_isa_pkg::gpr_addr_t i_inst_rd,
    input  rv_isa_pkg::data_t     i_inst_imm,
    input  logic                  i_is_illegal,
    input  logic                  i_is_alu,
    input  logic                  i_is_ecall,
    input  logic                  i_is_ebreak,
    input  logic                  i_is_mret,
    input  logic                  i_is_csr,
    input  rv_isa_pkg::data_t     i_alu_result
);

    exec_pkg::ret_kind_t kind;
    logic                fire;
    logic                we;

    always_comb
    begin
        if (i_is_illegal)
            kind = exec_pkg::RET_ILLEGAL;
        else if (i_is_alu || i_inst_op == rv_isa_pkg::OPCODE_LUI ||
                 i_inst_op == rv_isa_pkg::OPCODE_AUIPC)
            kind = exec_pkg::RET_ALU;
        else if (i_is_csr)
            kind = exec_pkg::RET_CSR;
        else if (i_is_ecall)
            kind = exec_pkg::RET_ECALL;
        else if (i_is_ebreak)
            kind = exec_pkg::RET_EBREAK;
        else if (i_is_mret)
            kind = exec_pkg::RET_MRET;
        else
            kind = exec_pkg::RET_OTHER;    // Loads, stores, jumps and branches
    end

    assign fire = i_head_valid && i_ret_ready;     // Pop and push on the same edge
    assign we   = (kind == exec_pkg::RET_ALU) && (i_inst_rd != '0);

    assign o_head_ready = i_ret_ready;
    assign o_ret_valid  = i_head_valid;

    assign rf.rs1_addr = i_inst_rs1;
    assign rf.rs2_addr = i_inst_rs2;
    assign rf.wr_en    = fire && we;
    assign rf.wr_addr  = i_inst_rd;
    assign rf.wr_data  = i_alu_result;

    assign o_ret.pc    = i_head.pc;
    assign o_ret.kind  = kind;
    assign o_ret.rd    = i_inst_rd;
    assign o_ret.we    = we;
    assign o_ret.value = (kind == exec_pkg::RET_ALU) ? i_alu_result : i_inst_imm;

endmodule

// File: exec_pkg.sv
package exec_pkg;

    // Input queue entry of 64 bits
    typedef struct packed {
        rv_isa_pkg::inst_t inst;
        rv_isa_pkg::data_t pc;
    } fetch_t;

    typedef enum logic [2:0] {
        RET_ALU     = 3'd0,     // Executed here with the result in value
        RET_OTHER   = 3'd1,     // Memory and control flow with the immediate in value
        RET_CSR     = 3'd2,
        RET_ECALL   = 3'd3,
        RET_EBREAK  = 3'd4,
        RET_MRET    = 3'd5,
        RET_ILLEGAL = 3'd6
    } ret_kind_t;

    // Retire record of 73 bits
    typedef struct packed {
        rv_isa_pkg::data_t     pc;
        ret_kind_t             kind;
        rv_isa_pkg::gpr_addr_t rd;
        logic                  we;      // rd was written
        rv_isa_pkg::data_t     value;
    } retire_t;

endpackage

// File: inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  rv_isa_pkg::inst_t     i_inst,
    output rv_isa_pkg::opcode_t   o_inst_op,
    output rv_isa_pkg::gpr_addr_t o_inst_rs1,
    output rv_isa_pkg::gpr_addr_t o_inst_rs2,
    output rv_isa_pkg::gpr_addr_t o_inst_rd,
    output rv_isa_pkg::csr_addr_t o_inst_csr,
    output rv_isa_pkg::data_t     o_inst_imm,
    output logic                  o_is_illegal,
    output logic                  o_is_alu,
    output logic                  o_is_ecall,
    output logic                  o_is_ebreak,
    output logic                  o_is_mret,
    output logic                  o_is_csr
);

    rv_isa_pkg::data_t imm_i;
    rv_isa_pkg::data_t imm_s;
    rv_isa_pkg::data_t imm_b;
    rv_isa_pkg::data_t imm_u;
    rv_isa_pkg::data_t imm_j;
    rv_isa_pkg::data_t imm_shamt;
    rv_isa_pkg::data_t imm_csr;
    logic [16:0]       key;         // funct7, funct3, opcode

    assign imm_i     = rv_isa_pkg::data_t'($signed(i_inst[31:20]));
    assign imm_s     = rv_isa_pkg::data_t'($signed({i_inst[31:25], i_inst[11:7]}));
    assign imm_b     = rv_isa_pkg::data_t'($signed({i_inst[31], i_inst[7],
                                                    i_inst[30:25], i_inst[11:8], 1'b0}));
    assign imm_u     = {i_inst[31:12], 12'h000};
    assign imm_j     = rv_isa_pkg::data_t'($signed({i_inst[31], i_inst[19:12],
                                                    i_inst[20], i_inst[30:21], 1'b0}));
    assign imm_shamt = rv_isa_pkg::data_t'(i_inst[24:20]);
    assign imm_csr   = rv_isa_pkg::data_t'(i_inst[19:15]);   // Zero extended uimm
    assign key       = {i_inst[31:25], i_inst[14:12], i_inst[6:0]};

    assign o_inst_op  = rv_isa_pkg::opcode_t'(i_inst[6:0]);
    assign o_inst_rs1 = i_inst[19:15];
    assign o_inst_rs2 = i_inst[24:20];
    assign o_inst_rd  = i_inst[11:7];
    assign o_inst_csr = i_inst[31:20];

    always_comb
    begin
        o_inst_imm   = '0;
        o_is_illegal = 1'b0;
        o_is_alu     = 1'b0;
        o_is_ecall   = 1'b0;
        o_is_ebreak  = 1'b0;
        o_is_mret    = 1'b0;
        o_is_csr     = 1'b0;

        unique casez (key)
            {10'b???????_???, rv_isa_pkg::OPCODE_LUI},
            {10'b???????_???, rv_isa_pkg::OPCODE_AUIPC}:
                o_inst_imm = imm_u;
            {10'b???????_???, rv_isa_pkg::OPCODE_JAL}:
                o_inst_imm = imm_j;
            {10'b???????_000, rv_isa_pkg::OPCODE_JALR},
            {10'b???????_00?, rv_isa_pkg::OPCODE_LOAD},      // LB LH
            {10'b???????_010, rv_isa_pkg::OPCODE_LOAD},      // LW
            {10'b???????_10?, rv_isa_pkg::OPCODE_LOAD}:      // LBU LHU
                o_inst_imm = imm_i;
            {10'b???????_00?, rv_isa_pkg::OPCODE_BRANCH},    // BEQ BNE
            {10'b???????_1??, rv_isa_pkg::OPCODE_BRANCH}:    // BLT BGE BLTU BGEU
                o_inst_imm = imm_b;
            {10'b???????_00?, rv_isa_pkg::OPCODE_STORE},     // SB SH
            {10'b???????_010, rv_isa_pkg::OPCODE_STORE}:     // SW
                o_inst_imm = imm_s;
            {10'b0000000_001, rv_isa_pkg::OPCODE_OP_IMM},    // SLLI
            {10'b0?00000_101, rv_isa_pkg::OPCODE_OP_IMM}:    // SRLI SRAI
            begin
                o_inst_imm = imm_shamt;
                o_is_alu   = 1'b1;
            end
            {10'b???????_000, rv_isa_pkg::OPCODE_OP_IMM},    // ADDI
            {10'b???????_01?, rv_isa_pkg::OPCODE_OP_IMM},    // SLTI SLTIU
            {10'b???????_100, rv_isa_pkg::OPCODE_OP_IMM},    // XORI
            {10'b???????_11?, rv_isa_pkg::OPCODE_OP_IMM}:    // ORI ANDI
            begin
                o_inst_imm = imm_i;
                o_is_alu   = 1'b1;
            end
            {10'b0000000_???, rv_isa_pkg::OPCODE_OP},
            {10'b0100000_000, rv_isa_pkg::OPCODE_OP},        // SUB
            {10'b0100000_101, rv_isa_pkg::OPCODE_OP}:        // SRA
                o_is_alu = 1'b1;
            {10'b???????_000, rv_isa_pkg::OPCODE_SYSTEM}:
            begin
                if (i_inst[19:15] != '0 || i_inst[11:7] != '0)
                    o_is_illegal = 1'b1;
                else if (i_inst[31:20] == rv_isa_pkg::SYS_IMM_ECALL)
                    o_is_ecall = 1'b1;
                else if (i_inst[31:20] == rv_isa_pkg::SYS_IMM_EBREAK)
                    o_is_ebreak = 1'b1;
                else if (i_inst[31:20] == rv_isa_pkg::SYS_IMM_MRET)
                    o_is_mret = 1'b1;
                else
                    o_is_illegal = 1'b1;
            end
            {10'b???????_001, rv_isa_pkg::OPCODE_SYSTEM},    // CSRRW
            {10'b???????_01?, rv_isa_pkg::OPCODE_SYSTEM}:    // CSRRS CSRRC
                o_is_csr = 1'b1;
            {10'b???????_101, rv_isa_pkg::OPCODE_SYSTEM},    // CSRRWI
            {10'b???????_11?, rv_isa_pkg::OPCODE_SYSTEM}:    // CSRRSI CSRRCI
            begin
                o_inst_imm = imm_csr;
                o_is_csr   = 1'b1;
            end
            default:                                         // FENCE, M extension and the rest
                o_is_illegal = 1'b1;
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic      i_clock,
    input  logic      i_reset,
    regfile_if.storage rf
);

    rv_isa_pkg::data_t regs [rv_isa_pkg::NUM_GPRS];

    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < rv_isa_pkg::NUM_GPRS; i++)
                regs[i] <= '0;
        end
        else if (rf.wr_en && rf.wr_addr != '0)  // x0 stays zero
        begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

endmodule

// File: regfile_if.sv
`timescale 1ns/10ps

interface regfile_if;

    rv_isa_pkg::gpr_addr_t rs1_addr;
    rv_isa_pkg::gpr_addr_t rs2_addr;
    rv_isa_pkg::data_t     rs1_data;
    rv_isa_pkg::data_t     rs2_data;
    logic                  wr_en;
    rv_isa_pkg::gpr_addr_t wr_addr;
    rv_isa_pkg::data_t     wr_data;

    modport control (
        output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
        input  rs1_data, rs2_data
    );

    modport storage (
        input  rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
        output rs1_data, rs2_data
    );

endinterface

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f compile.f --top-module tb_rv_exec_unit || exit 1
./obj_dir/Vtb_rv_exec_unit | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: rv_exec_unit.sv
`timescale 1ns/10ps

module rv_exec_unit #(
    parameter int IN_DEPTH  = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_inst_valid,
    output logic                  o_inst_ready,
    input  rv_isa_pkg::inst_t     i_inst,
    input  rv_isa_pkg::data_t     i_pc,
    output logic                  o_ret_valid,
    input  logic                  i_ret_ready,
    output rv_isa_pkg::data_t     o_ret_pc,
    output exec_pkg::ret_kind_t   o_ret_kind,
    output rv_isa_pkg::gpr_addr_t o_ret_rd,
    output logic                  o_ret_we,
    output rv_isa_pkg::data_t     o_ret_value
);

    exec_pkg::fetch_t      in_entry;
    exec_pkg::fetch_t      head;
    logic                  head_valid;
    logic                  head_ready;
    exec_pkg::retire_t     ret_entry;
    exec_pkg::retire_t     out_entry;
    logic                  ret_valid;
    logic                  ret_ready;
    rv_isa_pkg::opcode_t   dec_op;
    rv_isa_pkg::gpr_addr_t dec_rs1;
    rv_isa_pkg::gpr_addr_t dec_rs2;
    rv_isa_pkg::gpr_addr_t dec_rd;
    rv_isa_pkg::data_t     dec_imm;
    logic                  is_illegal;
    logic                  is_alu;
    logic                  is_ecall;
    logic                  is_ebreak;
    logic                  is_mret;
    logic                  is_csr;
    rv_isa_pkg::data_t     alu_result;

    regfile_if rf_bus ();

    assign in_entry = '{inst: i_inst, pc: i_pc};

    assign o_ret_pc    = out_entry.pc;
    assign o_ret_kind  = out_entry.kind;
    assign o_ret_rd    = out_entry.rd;
    assign o_ret_we    = out_entry.we;
    assign o_ret_value = out_entry.value;

    stream_fifo #(.T(exec_pkg::fetch_t), .DEPTH(IN_DEPTH)) u_in_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (i_inst_valid),
        .o_ready (o_inst_ready),
        .i_data  (in_entry),
        .o_valid (head_valid),
        .i_ready (head_ready),
        .o_data  (head)
    );

    inst_decoder u_decoder (
        .i_inst       (head.inst),
        .o_inst_op    (dec_op),
        .o_inst_rs1   (dec_rs1),
        .o_inst_rs2   (dec_rs2),
        .o_inst_rd    (dec_rd),
        .o_inst_csr   (),           // CSR file lives in a later stage
        .o_inst_imm   (dec_imm),
        .o_is_illegal (is_illegal),
        .o_is_alu     (is_alu),
        .o_is_ecall   (is_ecall),
        .o_is_ebreak  (is_ebreak),
        .o_is_mret    (is_mret),
        .o_is_csr     (is_csr)
    );

    alu_unit u_alu (
        .i_inst     (head.inst),
        .i_pc       (head.pc),
        .i_rs1_data (rf_bus.rs1_data),
        .i_rs2_data (rf_bus.rs2_data),
        .i_imm      (dec_imm),
        .o_result   (alu_result)
    );

    reg_file u_reg_file (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .rf      (rf_bus.storage)
    );

    exec_control u_control (
        .i_head_valid (head_valid),
        .o_head_ready (head_ready),
        .i_head       (head),
        .o_ret_valid  (ret_valid),
        .i_ret_ready  (ret_ready),
        .o_ret        (ret_entry),
        .rf           (rf_bus.control),
        .i_inst_op    (dec_op),
        .i_inst_rs1   (dec_rs1),
        .i_inst_rs2   (dec_rs2),
        .i_inst_rd    (dec_rd),
        .i_inst_imm   (dec_imm),
        .i_is_illegal (is_illegal),
        .i_is_alu     (is_alu),
        .i_is_ecall   (is_ecall),
        .i_is_ebreak  (is_ebreak),
        .i_is_mret    (is_mret),
        .i_is_csr     (is_csr),
        .i_alu_result (alu_result)
    );

    stream_fifo #(.T(exec_pkg::retire_t), .DEPTH(OUT_DEPTH)) u_out_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (ret_valid),
        .o_ready (ret_ready),
        .i_data  (ret_entry),
        .o_valid (o_ret_valid),
        .i_ready (i_ret_ready),
        .o_data  (out_entry)
    );

endmodule

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN       = 32;                 // Register and pc width
    localparam int INST_W     = 32;
    localparam int GPR_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int NUM_GPRS   = 1 << GPR_ADDR_W;    // x0 to x31

    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [XLEN-1:0]       data_t;
    typedef logic [GPR_ADDR_W-1:0] gpr_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Major opcodes of the base integer set
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_FENCE  = 7'b0001111,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_t;

    // Immediate field of the funct3 = 000 system instructions
    localparam csr_addr_t SYS_IMM_ECALL  = 12'h000;
    localparam csr_addr_t SYS_IMM_EBREAK = 12'h001;
    localparam csr_addr_t SYS_IMM_MRET   = 12'h302;

endpackage

// File: stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4
) (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;    // Wrap for any depth
    endfunction

    assign o_ready = (count != CNT_W'(DEPTH));     // Not full
    assign o_valid = (count != '0);                // Not empty
    assign o_data  = mem[rd_ptr];
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (push)
            mem[wr_ptr] <= i_data;
    end

endmodule

// File: tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic rv_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic rv_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_isa_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic rv_isa_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic rv_isa_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic rv_isa_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Integer result for funct3 and the SUB or SRA variant
function automatic rv_isa_pkg::data_t alu_calc(input logic [2:0] f3, input logic sub,
                                               input logic sra, input rv_isa_pkg::data_t a,
                                               input rv_isa_pkg::data_t b);
    case (f3)
        3'd0:    return sub ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return sra ? rv_isa_pkg::data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic exec_pkg::retire_t ref_retire(input rv_isa_pkg::inst_t inst,
                                                 input rv_isa_pkg::data_t pc,
                                                 inout rv_isa_pkg::data_t regs [32]);
    exec_pkg::retire_t r;
    logic [2:0]        f3;
    logic [6:0]        f7;
    rv_isa_pkg::data_t imm_i;
    rv_isa_pkg::data_t imm_u;
    f3    = inst[14:12];
    f7    = inst[31:25];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'h000};
    r     = '{pc: pc, kind: exec_pkg::RET_ILLEGAL, rd: inst[11:7], we: 1'b0, value: '0};
    case (inst[6:0])
        7'b0110111: r = '{pc, exec_pkg::RET_ALU, inst[11:7], 1'b0, imm_u};
        7'b0010111: r = '{pc, exec_pkg::RET_ALU, inst[11:7], 1'b0, pc + imm_u};
        7'b1101111: r = '{pc, exec_pkg::RET_OTHER, inst[11:7], 1'b0,
                          {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}};
        7'b1100111:
            if (f3 == 3'd0)
                r = '{pc, exec_pkg::RET_OTHER, inst[11:7], 1'b0, imm_i};
        7'b0000011:
            if (f3 != 3'd3 && f3 < 3'd6)
                r = '{pc, exec_pkg::RET_OTHER, inst[11:7], 1'b0, imm_i};
        7'b0100011:
            if (f3 < 3'd3)
                r = '{pc, exec_pkg::RET_OTHER, inst[11:7], 1'b0,
                      {{20{inst[31]}}, inst[31:25], inst[11:7]}};
        7'b1100011:
            if (f3 != 3'd2 && f3 != 3'd3)
                r = '{pc, exec_pkg::RET_OTHER, inst[11:7], 1'b0,
                      {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}};
        7'b0010011:
            if (f3 == 3'd1 ? f7 == 7'h00 : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20))
                r = '{pc, exec_pkg::RET_ALU, inst[11:7], 1'b0,
                      alu_calc(f3, 1'b0, f7[5], regs[inst[19:15]],
                               (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, inst[24:20]} : imm_i)};
        7'b0110011:
            if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                r = '{pc, exec_pkg::RET_ALU, inst[11:7], 1'b0,
                      alu_calc(f3, f7[5], f7[5], regs[inst[19:15]], regs[inst[24:20]])};
        7'b1110011:
            if (f3 == 3'd0 && inst[19:7] == '0 && inst[31:20] == 12'h000)
                r.kind = exec_pkg::RET_ECALL;
            else if (f3 == 3'd0 && inst[19:7] == '0 && inst[31:20] == 12'h001)
                r.kind = exec_pkg::RET_EBREAK;
            else if (f3 == 3'd0 && inst[19:7] == '0 && inst[31:20] == 12'h302)
                r.kind = exec_pkg::RET_MRET;
            else if (f3 != 3'd0 && f3 != 3'd4)
            begin
                r.kind  = exec_pkg::RET_CSR;
                r.value = f3[2] ? {27'd0, inst[19:15]} : '0;   // uimm only for the I forms
            end
        default: ;
    endcase
    if (r.kind == exec_pkg::RET_ALU && r.rd != 5'd0)
    begin
        r.we        = 1'b1;
        regs[r.rd]  = r.value;
    end
    return r;
endfunction

`endif

// File: tb_rv_exec_unit.sv
`timescale 1ns/10ps

module tb_rv_exec_unit;

    logic                  i_clock;
    logic                  i_reset;
    logic                  i_inst_valid;
    logic                  o_inst_ready;
    rv_isa_pkg::inst_t     i_inst;
    rv_isa_pkg::data_t     i_pc;
    logic                  o_ret_valid;
    logic                  i_ret_ready;
    rv_isa_pkg::data_t     o_ret_pc;
    exec_pkg::ret_kind_t   o_ret_kind;
    rv_isa_pkg::gpr_addr_t o_ret_rd;
    logic                  o_ret_we;
    rv_isa_pkg::data_t     o_ret_value;

    integer                seed = 32'hcf6957bd;
    rv_isa_pkg::data_t     model_regs [32];
    exec_pkg::retire_t     exp_q [$];
    rv_isa_pkg::data_t     pc;
    int                    errors = 0;
    int                    sent = 0;
    int                    checked = 0;
    int                    ready_mode = 0;     // 0 always, 1 random, 2 held low
    logic                  gaps_on = 1'b0;
    logic                  saw_stall = 1'b0;
    longint                cycles = 0;

    `include "tb_ref_model.svh"

    rv_exec_unit #(.IN_DEPTH(4), .OUT_DEPTH(4)) u_dut (.*);

    always #50 i_clock = ~i_clock;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic send(input rv_isa_pkg::inst_t inst);
        logic accepted;
        if (gaps_on && rnd(3) == 0)
        begin
            i_inst_valid = 1'b0;               // Idle cycle
            @(posedge i_clock);
            #10;
        end
        exp_q.push_back(ref_retire(inst, pc, model_regs));
        i_inst       = inst;
        i_pc         = pc;
        i_inst_valid = 1'b1;
        sent++;
        accepted = 1'b0;
        while (!accepted)
        begin
            accepted = o_inst_ready;           // Stable since the last edge
            @(posedge i_clock);
            #10;
        end
        i_inst_valid = 1'b0;
        pc += 4;
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before,
                               input int sent_before);
        while (exp_q.size() != 0)
            @(posedge i_clock);
        #10;
        $display("test %0d %s: %0d instructions, %0d errors", num, name,
                 sent - sent_before, errors - errs_before);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act)
        else
        begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic rv_isa_pkg::inst_t rand_alu(input logic imm_form, input logic [2:0] f3,
                                                   input logic alt);
        logic [4:0] rd;
        logic [4:0] rs1;
        rd  = 5'(1 + rnd(8));
        rs1 = 5'(1 + rnd(8));
        if (!imm_form)
            return enc_r({1'b0, alt, 5'd0}, 5'(1 + rnd(8)), rs1, f3, rd, 7'b0110011);
        if (f3 == 3'd1 || f3 == 3'd5)
            return enc_i({1'b0, alt, 5'd0, 5'(rnd(32))}, rs1, f3, rd, 7'b0010011);
        return enc_i(12'($random(seed)), rs1, f3, rd, 7'b0010011);
    endfunction

    // Compare each record one half period before its transfer edge
    always @(negedge i_clock)
    begin
        exec_pkg::retire_t exp;
        if (ready_mode == 2 && !o_inst_ready)
            saw_stall = 1'b1;
        if (!i_reset && o_ret_valid && i_ret_ready)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("Record for pc %h arrived with no instruction outstanding", o_ret_pc);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                exp = exp_q.pop_front();
                check_field("o_ret_pc", exp.pc, o_ret_pc);
                check_field("o_ret_kind", 32'(exp.kind), 32'(o_ret_kind));
                check_field("o_ret_rd", 32'(exp.rd), 32'(o_ret_rd));
                check_field("o_ret_we", 32'(exp.we), 32'(o_ret_we));
                check_field("o_ret_value", exp.value, o_ret_value);
                checked++;
            end
        end
    end

    initial
    begin
        forever
        begin
            @(posedge i_clock);
            #10;
            i_ret_ready = (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? 1'(rnd(2)) : 1'b0;
        end
    end

    // Budget grows with every instruction sent
    always @(posedge i_clock)
    begin
        cycles++;
        if (cycles > longint'(sent) * 200 + 2000)
        begin
            $display("Watchdog timeout after %0d cycles with %0d records missing",
                     cycles, exp_q.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial
    begin
        int e0;
        int s0;
        i_clock      = 1'b0;
        i_reset      = 1'b1;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        i_ret_ready  = 1'b1;
        pc           = 32'h0000_1000;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (3) @(posedge i_clock);
        #10;
        i_reset = 1'b0;

        e0 = errors;
        s0 = sent;
        for (int r = 1; r <= 8; r++)
            send(enc_i(12'($random(seed)), 5'(rnd(8)), 3'd0, 5'(r), 7'b0010011));
        repeat (3)
            for (int f = 0; f < 8; f++)
            begin
                send(rand_alu(1'b0, 3'(f), 1'b0));
                send(rand_alu(1'b1, 3'(f), 1'b0));
                if (f == 0 || f == 5)
                    send(rand_alu(1'b0, 3'(f), 1'b1));       // SUB and SRA
                if (f == 5)
                    send(rand_alu(1'b1, 3'(f), 1'b1));       // SRAI
            end
        finish_test(1, "alu ops", e0, s0);

        e0 = errors;
        s0 = sent;
        for (int k = 0; k < 8; k++)
        begin
            send(enc_u(20'($random(seed)), 5'(1 + rnd(8)), 7'b0110111));
            send(enc_u(20'($random(seed)), 5'(1 + rnd(8)), 7'b0010111));
        end
        finish_test(2, "lui auipc", e0, s0);

        e0 = errors;
        s0 = sent;
        send(enc_i(12'h7ff, 5'd1, 3'd0, 5'd0, 7'b0010011));
        send(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0, 7'b0110011));
        send(enc_u(20'habcde, 5'd0, 7'b0110111));
        send(enc_r(7'd0, 5'd0, 5'd0, 3'd6, 5'd9, 7'b0110011));
        send(enc_i(12'h123, 5'd0, 3'd4, 5'd10, 7'b0010011));
        finish_test(3, "x0 writes", e0, s0);

        e0 = errors;
        s0 = sent;
        for (int f = 0; f < 8; f++)
        begin
            send(enc_i(12'($random(seed)), 5'(rnd(32)), 3'(f), 5'(rnd(32)), 7'b0000011));
            send(enc_s(12'($random(seed)), 5'(rnd(32)), 5'(rnd(32)), 3'(f)));
            send(enc_b(13'($random(seed)), 5'(rnd(32)), 5'(rnd(32)), 3'(f)));
        end
        send(enc_j(21'($random(seed)), 5'd1));
        send(enc_i(12'($random(seed)), 5'd2, 3'd0, 5'd3, 7'b1100111));
        send(enc_r(7'd0, 5'd3, 5'd1, 3'd0, 5'd11, 7'b0110011));   // Registers unchanged
        finish_test(4, "memory and control", e0, s0);

        e0 = errors;
        s0 = sent;
        for (int f = 1; f < 8; f++)
            if (f != 4)
                send(enc_i(12'h300, 5'(rnd(32)), 3'(f), 5'(rnd(32)), 7'b1110011));
        send(32'h0000_0073);
        send(32'h0010_0073);
        send(32'h3020_0073);
        send(enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, 7'b0001111));
        send(enc_r(7'd1, 5'd2, 5'd1, 3'(rnd(8)), 5'd5, 7'b0110011));
        for (int k = 0; k < 10; k++)
            send(rv_isa_pkg::inst_t'($random(seed)));
        finish_test(5, "system and illegal", e0, s0);

        e0 = errors;
        s0 = sent;
        gaps_on    = 1'b1;
        ready_mode = 2;
        fork
            for (int k = 0; k < 40; k++)
                send(rand_alu(1'(rnd(2)), 3'(rnd(8)), 1'b0));
            begin
                repeat (40) @(posedge i_clock);
                ready_mode = 1;
            end
        join
        assert (saw_stall)
        else
        begin
            $display("Input ready never dropped while the output was held off");
            errors++;
        end
        finish_test(6, "back-pressure", e0, s0);

        $display("%0d tests, %0d sent, %0d checked, %0d errors", 6, sent, checked, errors);
        if (errors == 0 && checked == sent)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
